/* br_macros.svh */
`ifndef BR_MACROS_SVH
`define BR_MACROS_SVH

// ----------------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------------
`define BR_XLEN 32   // Data and address width
`define BR_PHY_W 8   // Physical register number
`define BR_TAG_W 32  // Instruction sequence number

// ----------------------------------------------------------------------------
// Instruction size for fall-through and link value
// ----------------------------------------------------------------------------
`define BR_LINK_OFFSET 32'd4

`endif

/* br_pkg.sv */
package br_pkg;

    // ------------------------------------------------------------------------
    // Conditional branch compare, funct3 encoding
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,   // Signed
        BGE  = 3'd5,   // Signed
        BLTU = 3'd6,
        BGEU = 3'd7
    } br_cond_e;

    // Codes 2 and 3 have no branch meaning

    // ------------------------------------------------------------------------
    // Kind of instruction held in the stage buffer
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,   // Empty slot
        KIND_BRANCH = 2'd1,
        KIND_JAL    = 2'd2,
        KIND_JALR   = 2'd3    // Jump with return flag
    } br_kind_e;

    // Jumps are always taken, conditional branches depend on flags.
    // KIND_NONE marks a bubble and never produces any outputs
    // downstream of the buffer.

endpackage

/* br_flag_unit.sv */
`timescale 1ns/100ps
`include "br_macros.svh"

module br_flag_unit (
    input  logic [`BR_XLEN-1:0] operand1,
    input  logic [`BR_XLEN-1:0] operand2,
    output logic                negative,
    output logic                zero,
    output logic                overflow,
    output logic                carry
);

    // ------------------------------------------------------------------------
    // Subtract as operand1 + ~operand2 + 1, one extra bit for carry out
    // ------------------------------------------------------------------------
    logic [`BR_XLEN:0]   sum;
    logic [`BR_XLEN-1:0] diff;
    logic                sign1;
    logic                sign2;
    logic                sign_d;

    assign sum  = {1'b0, operand1} + {1'b0, ~operand2} + {{`BR_XLEN{1'b0}}, 1'b1};
    assign diff = sum[`BR_XLEN-1:0];

    assign sign1  = operand1[`BR_XLEN-1];
    assign sign2  = operand2[`BR_XLEN-1];
    assign sign_d = diff[`BR_XLEN-1];

    // ------------------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------------------
    assign negative = sign_d;
    assign zero     = (diff == '0);

    // Operands of different sign and result sign flips away from operand1
    assign overflow = (sign1 != sign2) && (sign_d != sign1);

    assign carry = sum[`BR_XLEN];   // Set when no borrow

    // A signed less-than is then negative ^ overflow, an unsigned
    // less-than is simply a missing carry. Equality only needs zero.

endmodule

/* br_stage_buffer.sv */
`timescale 1ns/100ps
`include "br_macros.svh"

module br_stage_buffer import br_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 is_return,
    input  logic                 pred_taken,
    input  logic                 pred_hit,
    input  logic [`BR_PHY_W-1:0] dest_phy,
    input  logic [`BR_TAG_W-1:0] inst_num,
    input  logic [`BR_XLEN-1:0]  immediate,
    input  logic [`BR_XLEN-1:0]  pc,
    input  logic [`BR_XLEN-1:0]  operand1,
    input  logic [2:0]           funct3,
    input  logic                 negative,
    input  logic                 zero,
    input  logic                 overflow,
    input  logic                 carry,
    output br_kind_e             b_kind,
    output logic                 b_pred_taken,
    output logic                 b_pred_hit,
    output logic [`BR_PHY_W-1:0] b_dest_phy,
    output logic [`BR_TAG_W-1:0] b_inst_num,
    output logic [`BR_XLEN-1:0]  b_immediate,
    output logic [`BR_XLEN-1:0]  b_pc,
    output logic [`BR_XLEN-1:0]  b_operand1,
    output logic [2:0]           b_funct3,
    output logic                 b_negative,
    output logic                 b_zero,
    output logic                 b_overflow,
    output logic                 b_carry
);

    // ------------------------------------------------------------------------
    // Strobe encoding
    // ------------------------------------------------------------------------
    br_kind_e kind_next;

    always_comb begin
        if (is_branch) begin
            kind_next = KIND_BRANCH;
        end else if (is_jump) begin
            kind_next = is_return ? KIND_JALR : KIND_JAL;
        end else begin
            kind_next = KIND_NONE;   // Bubble
        end
    end

    // ------------------------------------------------------------------------
    // Control and flag registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            b_kind       <= KIND_NONE;
            b_pred_taken <= 1'b0;
            b_pred_hit   <= 1'b0;
            b_negative   <= 1'b0;
            b_zero       <= 1'b0;
            b_overflow   <= 1'b0;
            b_carry      <= 1'b0;
        end else begin
            b_kind       <= kind_next;
            b_pred_taken <= pred_taken;
            b_pred_hit   <= pred_hit;
            b_negative   <= negative;
            b_zero       <= zero;
            b_overflow   <= overflow;
            b_carry      <= carry;
        end
    end

    // Payload, qualified by b_kind downstream
    always_ff @(posedge clk) begin
        b_dest_phy  <= dest_phy;
        b_inst_num  <= inst_num;
        b_immediate <= immediate;
        b_pc        <= pc;
        b_operand1  <= operand1;
        b_funct3    <= funct3;
    end

    // Issue side sends one kind per cycle
    a_one_kind : assert property (
        @(posedge clk) disable iff (reset) !(is_branch && is_jump)
    );

endmodule

/* br_resolve.sv */
`timescale 1ns/100ps
`include "br_macros.svh"

module br_resolve import br_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  br_kind_e             b_kind,
    input  logic                 b_pred_taken,
    input  logic                 b_pred_hit,
    input  logic [`BR_PHY_W-1:0] b_dest_phy,
    input  logic [`BR_TAG_W-1:0] b_inst_num,
    input  logic [`BR_XLEN-1:0]  b_immediate,
    input  logic [`BR_XLEN-1:0]  b_pc,
    input  logic [`BR_XLEN-1:0]  b_operand1,
    input  logic [2:0]           b_funct3,
    input  logic                 b_negative,
    input  logic                 b_zero,
    input  logic                 b_overflow,
    input  logic                 b_carry,
    output logic                 resolve_valid,
    output logic [`BR_TAG_W-1:0] resolve_inst_num,
    output logic                 actual_taken,
    output logic                 mispredict,
    output logic [`BR_XLEN-1:0]  redirect_pc,
    output logic                 wb_valid,
    output logic [`BR_PHY_W-1:0] wb_phy,
    output logic [`BR_XLEN-1:0]  wb_data
);

    br_cond_e            cond;
    logic                cond_taken;
    logic                is_jump;
    logic                valid;
    logic                taken;
    logic                miss;
    logic [`BR_XLEN-1:0] target;
    logic [`BR_XLEN-1:0] jalr_sum;
    logic [`BR_XLEN-1:0] fall_through;

    // ------------------------------------------------------------------------
    // Branch condition from buffered flags
    // ------------------------------------------------------------------------
    assign cond = br_cond_e'(b_funct3);

    always_comb begin
        case (cond)
            BEQ:     cond_taken = b_zero;
            BNE:     cond_taken = !b_zero;
            BLT:     cond_taken = b_negative != b_overflow;
            BGE:     cond_taken = b_negative == b_overflow;
            BLTU:    cond_taken = !b_carry;   // Borrow
            BGEU:    cond_taken = b_carry;
            default: cond_taken = 1'b0;
        endcase
    end

    assign valid   = (b_kind != KIND_NONE);
    assign is_jump = (b_kind == KIND_JAL) || (b_kind == KIND_JALR);
    assign taken   = is_jump || ((b_kind == KIND_BRANCH) && cond_taken);

    // Taken without a BTB entry also counts as a miss
    assign miss = valid && ((taken != b_pred_taken) || (taken && !b_pred_hit));

    // ------------------------------------------------------------------------
    // Target and link
    // ------------------------------------------------------------------------
    assign jalr_sum     = b_operand1 + b_immediate;
    assign fall_through = b_pc + `BR_LINK_OFFSET;

    always_comb begin
        if (b_kind == KIND_JALR) begin
            target = {jalr_sum[`BR_XLEN-1:1], 1'b0};
        end else begin
            target = b_pc + b_immediate;
        end
    end

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            actual_taken  <= 1'b0;
            mispredict    <= 1'b0;
            wb_valid      <= 1'b0;
        end else begin
            resolve_valid <= valid;
            actual_taken  <= taken;   // Low on bubbles
            mispredict    <= miss;
            wb_valid      <= is_jump;
        end
    end

    always_ff @(posedge clk) begin
        resolve_inst_num <= b_inst_num;
        redirect_pc      <= taken ? target : fall_through;
        wb_phy           <= b_dest_phy;
        wb_data          <= fall_through;   // Link value
    end

    // Issue never marks funct3 2 or 3 as a branch
    a_legal_cond : assert property (
        @(posedge clk) disable iff (reset)
        (b_kind == KIND_BRANCH) |-> !(b_funct3 inside {3'd2, 3'd3})
    );

endmodule

/* branch_unit.sv */
`timescale 1ns/100ps
`include "br_macros.svh"

module branch_unit import br_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 is_return,
    input  logic                 pred_taken,
    input  logic                 pred_hit,
    input  logic [`BR_PHY_W-1:0] dest_phy,
    input  logic [`BR_TAG_W-1:0] inst_num,
    input  logic [`BR_XLEN-1:0]  immediate,
    input  logic [`BR_XLEN-1:0]  pc,
    input  logic [`BR_XLEN-1:0]  operand1,
    input  logic [`BR_XLEN-1:0]  operand2,
    input  logic [2:0]           funct3,
    output logic                 resolve_valid,
    output logic [`BR_TAG_W-1:0] resolve_inst_num,
    output logic                 actual_taken,
    output logic                 mispredict,
    output logic [`BR_XLEN-1:0]  redirect_pc,
    output logic                 wb_valid,
    output logic [`BR_PHY_W-1:0] wb_phy,
    output logic [`BR_XLEN-1:0]  wb_data
);

    // ------------------------------------------------------------------------
    // Stage 0 flags
    // ------------------------------------------------------------------------
    logic negative;
    logic zero;
    logic overflow;
    logic carry;

    br_flag_unit flags (
        .operand1 (operand1),
        .operand2 (operand2),
        .negative (negative),
        .zero     (zero),
        .overflow (overflow),
        .carry    (carry)
    );

    // ------------------------------------------------------------------------
    // Buffer outputs
    // ------------------------------------------------------------------------
    br_kind_e             b_kind;
    logic                 b_pred_taken;
    logic                 b_pred_hit;
    logic [`BR_PHY_W-1:0] b_dest_phy;
    logic [`BR_TAG_W-1:0] b_inst_num;
    logic [`BR_XLEN-1:0]  b_immediate;
    logic [`BR_XLEN-1:0]  b_pc;
    logic [`BR_XLEN-1:0]  b_operand1;
    logic [2:0]           b_funct3;
    logic                 b_negative;
    logic                 b_zero;
    logic                 b_overflow;
    logic                 b_carry;

    br_stage_buffer buffer (
        .clk          (clk),
        .reset        (reset),
        .is_branch    (is_branch),
        .is_jump      (is_jump),
        .is_return    (is_return),
        .pred_taken   (pred_taken),
        .pred_hit     (pred_hit),
        .dest_phy     (dest_phy),
        .inst_num     (inst_num),
        .immediate    (immediate),
        .pc           (pc),
        .operand1     (operand1),
        .funct3       (funct3),
        .negative     (negative),
        .zero         (zero),
        .overflow     (overflow),
        .carry        (carry),
        .b_kind       (b_kind),
        .b_pred_taken (b_pred_taken),
        .b_pred_hit   (b_pred_hit),
        .b_dest_phy   (b_dest_phy),
        .b_inst_num   (b_inst_num),
        .b_immediate  (b_immediate),
        .b_pc         (b_pc),
        .b_operand1   (b_operand1),
        .b_funct3     (b_funct3),
        .b_negative   (b_negative),
        .b_zero       (b_zero),
        .b_overflow   (b_overflow),
        .b_carry      (b_carry)
    );

    // Resolve, one more cycle
    br_resolve resolve (
        .clk              (clk),
        .reset            (reset),
        .b_kind           (b_kind),
        .b_pred_taken     (b_pred_taken),
        .b_pred_hit       (b_pred_hit),
        .b_dest_phy       (b_dest_phy),
        .b_inst_num       (b_inst_num),
        .b_immediate      (b_immediate),
        .b_pc             (b_pc),
        .b_operand1       (b_operand1),
        .b_funct3         (b_funct3),
        .b_negative       (b_negative),
        .b_zero           (b_zero),
        .b_overflow       (b_overflow),
        .b_carry          (b_carry),
        .resolve_valid    (resolve_valid),
        .resolve_inst_num (resolve_inst_num),
        .actual_taken     (actual_taken),
        .mispredict       (mispredict),
        .redirect_pc      (redirect_pc),
        .wb_valid         (wb_valid),
        .wb_phy           (wb_phy),
        .wb_data          (wb_data)
    );

endmodule

/* branch_unit_tb.sv */
`timescale 1ns/100ps
`include "br_macros.svh"

module branch_unit_tb import br_pkg::*; ();

    typedef struct packed {
        logic                 is_branch;
        logic                 is_jump;
        logic                 is_return;
        logic                 pred_taken;
        logic                 pred_hit;
        logic [`BR_PHY_W-1:0] dest_phy;
        logic [`BR_TAG_W-1:0] inst_num;
        logic [`BR_XLEN-1:0]  immediate;
        logic [`BR_XLEN-1:0]  pc;
        logic [`BR_XLEN-1:0]  operand1;
        logic [`BR_XLEN-1:0]  operand2;
        logic [2:0]           funct3;
    } issue_t;

    typedef struct packed {
        logic [31:0]          issue_cycle;
        logic [`BR_TAG_W-1:0] inst_num;
        logic                 taken;
        logic                 mispredict;
        logic [`BR_XLEN-1:0]  redirect_pc;
        logic                 wb_valid;
        logic [`BR_PHY_W-1:0] wb_phy;
        logic [`BR_XLEN-1:0]  wb_data;
    } result_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 is_branch;
    logic                 is_jump;
    logic                 is_return;
    logic                 pred_taken;
    logic                 pred_hit;
    logic [`BR_PHY_W-1:0] dest_phy;
    logic [`BR_TAG_W-1:0] inst_num;
    logic [`BR_XLEN-1:0]  immediate;
    logic [`BR_XLEN-1:0]  pc;
    logic [`BR_XLEN-1:0]  operand1;
    logic [`BR_XLEN-1:0]  operand2;
    logic [2:0]           funct3;
    logic                 resolve_valid;
    logic [`BR_TAG_W-1:0] resolve_inst_num;
    logic                 actual_taken;
    logic                 mispredict;
    logic [`BR_XLEN-1:0]  redirect_pc;
    logic                 wb_valid;
    logic [`BR_PHY_W-1:0] wb_phy;
    logic [`BR_XLEN-1:0]  wb_data;

    integer      seed = 32'he945_19ee;
    logic [31:0] cycle = 32'd0;
    logic [31:0] next_inst = 32'd0;
    logic        checking = 1'b0;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    result_t     expected[$];

    branch_unit dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic result_t predict_resolve(input issue_t r);
        result_t             e;
        logic                taken;
        logic [`BR_XLEN-1:0] target;
        logic [`BR_XLEN-1:0] link;
        link = r.pc + `BR_LINK_OFFSET;
        taken = 1'b0;
        if (r.is_jump) begin
            taken = 1'b1;
        end else begin
            case (br_cond_e'(r.funct3))
                BEQ:     taken = (r.operand1 == r.operand2);
                BNE:     taken = (r.operand1 != r.operand2);
                BLT:     taken = ($signed(r.operand1) < $signed(r.operand2));
                BGE:     taken = ($signed(r.operand1) >= $signed(r.operand2));
                BLTU:    taken = (r.operand1 < r.operand2);
                BGEU:    taken = (r.operand1 >= r.operand2);
                default: taken = 1'b0;
            endcase
        end
        if (r.is_jump && r.is_return) begin
            target = (r.operand1 + r.immediate) & ~32'd1;
        end else begin
            target = r.pc + r.immediate;
        end
        e.issue_cycle = 32'd0;
        e.inst_num    = r.inst_num;
        e.taken       = taken;
        e.mispredict  = (taken != r.pred_taken) || (taken && !r.pred_hit);
        e.redirect_pc = taken ? target : link;
        e.wb_valid    = r.is_jump;
        e.wb_phy      = r.dest_phy;
        e.wb_data     = link;
        return e;
    endfunction

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic issue_t random_fields();
        issue_t r;
        r.is_branch  = 1'b0;
        r.is_jump    = 1'b0;
        r.is_return  = 1'b0;
        r.pred_taken = 1'(rnd());
        r.pred_hit   = 1'(rnd());
        r.dest_phy   = 8'(rnd());
        r.inst_num   = 32'd0;
        r.immediate  = rnd();
        r.pc         = rnd();
        r.operand1   = rnd();
        r.operand2   = rnd();
        r.funct3     = 3'(rnd());
        if (r.funct3 == 3'd2 || r.funct3 == 3'd3) begin
            r.funct3 = r.funct3 + 3'd4;   // Fold illegal codes onto BLTU, BGEU
        end
        return r;
    endfunction

    function automatic logic [63:0] operand_pair(input int p);
        case (p)
            0:       return {32'h0000_0005, 32'h0000_0005};
            1:       return {32'h0000_0010, 32'h0000_0020};
            2:       return {32'hffff_fff0, 32'h0000_0010};   // Signed less only
            3:       return {32'h0000_0010, 32'hffff_fff0};
            4:       return {32'h8000_0000, 32'h7fff_ffff};   // Overflow
            5:       return {32'h7fff_ffff, 32'h8000_0000};
            default: return {32'hffff_ffff, 32'hffff_ffff};
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic issue(input issue_t r);
        result_t e;
        @(posedge clk);
        r.inst_num = next_inst;
        next_inst  = next_inst + 1;
        is_branch  <= r.is_branch;
        is_jump    <= r.is_jump;
        is_return  <= r.is_return;
        pred_taken <= r.pred_taken;
        pred_hit   <= r.pred_hit;
        dest_phy   <= r.dest_phy;
        inst_num   <= r.inst_num;
        immediate  <= r.immediate;
        pc         <= r.pc;
        operand1   <= r.operand1;
        operand2   <= r.operand2;
        funct3     <= r.funct3;
        e = predict_resolve(r);
        e.issue_cycle = cycle + 1;   // Edge count once this edge is done
        expected.push_back(e);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            is_branch <= 1'b0;
            is_jump   <= 1'b0;
            is_return <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        idle(1);
        waited = 0;
        while (expected.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (expected.size() != 0) begin
            $display("test %s timed out with %0d results outstanding", name, expected.size());
            $display("RESULT: FAIL");
            $finish;
        end else begin
            if (error_count == errors_at_start) begin
                pass_count++;
                $display("test %s: passed", name);
            end else begin
                fail_count++;
                $display("test %s: failed with %0d errors",
                         name, error_count - errors_at_start);
            end
            errors_at_start = error_count;
        end
    endtask

    // ------------------------------------------------------------------------
    // Comparison, sampled mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : compare
        result_t e;
        if (checking && resolve_valid && expected.size() == 0) begin
            $display("resolve_valid high at cycle %0d with no issue outstanding", cycle);
            error_count++;
        end else if (checking && resolve_valid) begin
            e = expected.pop_front();
            if (cycle != e.issue_cycle + 2) begin
                $display("inst %h resolved at cycle %0d, expected cycle %0d",
                         e.inst_num, cycle, e.issue_cycle + 2);
                error_count++;
            end
            if (resolve_inst_num !== e.inst_num) begin
                $display("FAILED resolve_inst_num exp %h got %h", e.inst_num, resolve_inst_num);
                error_count++;
            end
            if (actual_taken !== e.taken) begin
                $display("FAILED actual_taken exp %h got %h", e.taken, actual_taken);
                error_count++;
            end
            if (mispredict !== e.mispredict) begin
                $display("FAILED mispredict exp %h got %h", e.mispredict, mispredict);
                error_count++;
            end
            if (redirect_pc !== e.redirect_pc) begin
                $display("FAILED redirect_pc exp %h got %h", e.redirect_pc, redirect_pc);
                error_count++;
            end
            if (wb_valid !== e.wb_valid) begin
                $display("FAILED wb_valid exp %h got %h", e.wb_valid, wb_valid);
                error_count++;
            end
            if (e.wb_valid && wb_phy !== e.wb_phy) begin
                $display("FAILED wb_phy exp %h got %h", e.wb_phy, wb_phy);
                error_count++;
            end
            if (e.wb_valid && wb_data !== e.wb_data) begin
                $display("FAILED wb_data exp %h got %h", e.wb_data, wb_data);
                error_count++;
            end
        end else if (checking && (actual_taken || mispredict || wb_valid)) begin
            $display("control output high without resolve_valid at cycle %0d", cycle);
            error_count++;
        end
    end

    initial begin : stimulus
        issue_t r;
        int     sel;
        reset      <= 1'b1;
        is_branch  <= 1'b0;
        is_jump    <= 1'b0;
        is_return  <= 1'b0;
        pred_taken <= 1'b0;
        pred_hit   <= 1'b0;
        dest_phy   <= '0;
        inst_num   <= '0;
        immediate  <= '0;
        pc         <= '0;
        operand1   <= '0;
        operand2   <= '0;
        funct3     <= '0;
        repeat (2) @(posedge clk);
        reset    <= 1'b0;
        checking = 1'b1;

        idle(6);
        finish_test("reset idle");

        for (int c = 0; c < 8; c++) begin
            for (int p = 0; p < 7 && c != 2 && c != 3; p++) begin
                r = random_fields();
                r.is_branch = 1'b1;
                r.funct3 = 3'(c);
                {r.operand1, r.operand2} = operand_pair(p);
                issue(r);
            end
        end
        finish_test("branch conditions");

        for (int i = 0; i < 8; i++) begin
            r = random_fields();
            r.is_jump      = 1'b1;
            r.is_return    = i[0];   // Alternate JAL and JALR
            r.operand1[0]  = 1'b1;
            r.immediate[0] = i[1];
            issue(r);
        end
        finish_test("jumps");

        for (int m = 0; m < 12; m++) begin
            r = random_fields();
            r.pred_taken = m[0];
            r.pred_hit   = m[1];
            r.is_branch  = (m < 8);
            r.is_jump    = (m >= 8);
            r.funct3     = 3'd0;
            r.operand2   = (m < 4) ? r.operand1 : r.operand1 + 32'd1;
            issue(r);
        end
        finish_test("mispredict");

        for (int n = 0; n < 300; n++) begin
            r = random_fields();
            sel = int'(rnd() % 4);
            r.is_branch = (sel < 2);
            r.is_jump   = (sel >= 2);
            r.is_return = (sel == 3);
            issue(r);
            if (rnd() % 3 == 0) begin
                idle(int'(1 + rnd() % 2));   // Gap between issues
            end
        end
        finish_test("random stream");

        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
br_pkg.sv
br_flag_unit.sv
br_stage_buffer.sv
br_resolve.sv
branch_unit.sv
branch_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module branch_unit_tb \
    -o branch_unit_sim &&
./obj_dir/branch_unit_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
